// File: sim.f
hw/lsu_bus_pkg.sv
hw/lsu_access_pkg.sv
hw/lsu_fsm.sv
hw/lsu_store_align.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
verif/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  # packages first, then the RTL in dependency order
  - files:
      - hw/lsu_bus_pkg.sv
      - hw/lsu_access_pkg.sv
      - hw/lsu_fsm.sv
      - hw/lsu_store_align.sv
      - hw/lsu_load_align.sv
      - hw/lsu_top.sv

  # testbench
  - target: test
    files:
      - verif/lsu_tb.sv

// File: verif/lsu_tb.sv
// testbench for the load/store unit
// clock and reset, bus memory model, address increment, directed tests, watchdog

`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  localparam int unsigned ClkPeriod     = 20;
  localparam int unsigned NumTests      = 6;
  localparam int unsigned CyclesPerTest = 40;
  localparam int unsigned WatchdogNs    = NumTests * CyclesPerTest * ClkPeriod;

  logic clk;
  logic rst_n;
  // core side
  logic                     lsu_req;
  lsu_access_pkg::lsu_cmd_t lsu_cmd;
  lsu_bus_pkg::data_t       rdata;
  logic                     rdata_valid, resp_valid, req_done, addr_incr;
  logic                     load_err, store_err, busy;
  logic [31:0]              addr_last;
  // bus side
  logic                     data_req;
  lsu_bus_pkg::bus_req_t    bus_req;
  logic                     data_gnt, data_rvalid, data_err;
  lsu_bus_pkg::data_t       data_rdata;

  logic [31:0] mem     [16];   // bus memory, word index is addr[5:2]
  logic [31:0] exp_mem [16];   // expected contents after stores
  logic [7:0]  lfsr;
  int          gnt_delay;      // wait cycles before each grant
  int          wait_cnt;
  logic        err_en;
  logic [3:0]  err_word;       // word that answers with data_err
  logic        nxt_gnt, nxt_rvalid, nxt_err;
  logic [31:0] nxt_rdata;
  // result of the last access
  logic [31:0] res_rdata, res_addr_last;
  logic        res_rdata_valid, res_load_err, res_store_err, res_incr;
  int          res_grants;
  int          res_rvalids;    // bus responses up to and including the core response
  int          check_cnt, err_cnt, test_cnt;

  lsu_top #(
    .AddrWidth (32)
  ) dut (
    .clk_i (clk), .rst_ni (rst_n),
    .lsu_req_i (lsu_req), .lsu_cmd_i (lsu_cmd),
    .lsu_rdata_o (rdata), .lsu_rdata_valid_o (rdata_valid),
    .lsu_resp_valid_o (resp_valid), .lsu_req_done_o (req_done),
    .addr_incr_req_o (addr_incr), .addr_last_o (addr_last),
    .load_err_o (load_err), .store_err_o (store_err), .busy_o (busy),
    .data_req_o (data_req), .bus_req_o (bus_req),
    .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_err_i (data_err), .data_rdata_i (data_rdata)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // bus memory model, decides at negedge and drives after the next posedge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : bus_model
    logic [3:0] widx;
    int         b;
    nxt_rvalid = 1'b0;
    nxt_err    = 1'b0;
    if (data_req && data_gnt) begin                // handshake at the coming edge
      widx = bus_req.addr[5:2];
      if (bus_req.we) begin
        for (b = 0; b < 4; b++) begin
          if (bus_req.be[b]) begin
            mem[widx][8*b +: 8] = bus_req.wdata[8*b +: 8];
          end
        end
      end
      nxt_rdata  = mem[widx];
      nxt_rvalid = 1'b1;                           // rvalid one cycle after grant
      nxt_err    = err_en && (widx == err_word);
      wait_cnt   = 0;
      nxt_gnt    = (gnt_delay == 0);
    end else if (data_req) begin
      wait_cnt = wait_cnt + 1;
      nxt_gnt  = (wait_cnt >= gnt_delay);
    end else begin
      wait_cnt = 0;
      nxt_gnt  = (gnt_delay == 0);                 // zero delay keeps grant up
    end
  end

  always @(posedge clk) begin
    #2;
    data_gnt    = nxt_gnt;
    data_rvalid = nxt_rvalid;
    data_err    = nxt_err;
    data_rdata  = nxt_rvalid ? nxt_rdata : '0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // galois step, taps x^8+x^6+x^5+x^4+1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    int          k;
    r = '0;
    for (k = 0; k < n; k++) begin
      r    = {r[30:0], lfsr[0]};                   // one bit per step
      lfsr = lfsr_next(lfsr);
    end
    return r;
  endfunction

  function automatic int size_bytes(input lsu_access_pkg::access_size_e size);
    if (size == lsu_access_pkg::SIZE_WORD) return 4;
    if (size == lsu_access_pkg::SIZE_HALF) return 2;
    return 1;
  endfunction

  // little endian value at a byte address, extended to 32 bit
  function automatic logic [31:0] load_value(input lsu_access_pkg::access_size_e size,
                                             input logic sext, input logic [31:0] addr);
    logic [31:0] w;
    logic [31:0] a;
    int          n;
    int          i;
    w = '0;
    n = size_bytes(size);
    for (i = 0; i < n; i++) begin
      a = addr + i;
      w[8*i +: 8] = mem[a[5:2]][8*a[1:0] +: 8];
    end
    if (sext && (n < 4) && w[8*n-1]) begin
      for (i = n; i < 4; i++) w[8*i +: 8] = 8'hFF;
    end
    return w;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    $display("test %-14s %s, %0d errors", name,
             (err_cnt == errs_before) ? "ok" : "failed", err_cnt - errs_before);
  endtask

  // one core request, holds the level until done and serves the next address
  task automatic run_access(input logic we, input lsu_access_pkg::access_size_e size,
                            input logic sext, input logic [31:0] addr, input logic [31:0] wdata);
    logic             held;
    logic             done;
    logic             resp;
    logic [31:0]      held_addr;
    lsu_bus_pkg::be_t held_be;
    held        = 1'b0;
    done        = 1'b0;
    resp        = 1'b0;
    res_grants  = 0;
    res_rvalids = 0;
    res_incr    = 1'b0;
    @(posedge clk);
    #2;
    lsu_cmd.we       = we;
    lsu_cmd.size     = size;
    lsu_cmd.sign_ext = sext;
    lsu_cmd.wdata    = wdata;
    lsu_cmd.addr     = addr;
    lsu_req          = 1'b1;
    while (!resp) begin
      @(negedge clk);
      if (held) begin                              // back-pressure, request must stay put
        check_value(data_req, 1'b1, "data_req_o dropped before grant");
        check_value(busy, 1'b1, "busy_o low while a request waits for grant");
        check_value(bus_req.addr, held_addr, "bus address changed while waiting");
        check_value(bus_req.be, held_be, "byte enables changed while waiting");
      end
      held      = data_req && !data_gnt;
      held_addr = bus_req.addr;
      held_be   = bus_req.be;
      if (data_req && data_gnt) res_grants++;
      if (data_rvalid) res_rvalids++;
      if (addr_incr) res_incr = 1'b1;
      if (req_done) done = 1'b1;
      if (resp_valid) begin
        resp            = 1'b1;
        res_rdata       = rdata;
        res_rdata_valid = rdata_valid;
        res_load_err    = load_err;
        res_store_err   = store_err;
        res_addr_last   = addr_last;
        check_value(done, 1'b1, "response before the request phase ended");
        check_value(busy, 1'b0, "busy_o still high with the response");
      end
      @(posedge clk);
      #2;
      if (done) lsu_req = 1'b0;
      lsu_cmd.addr = addr_incr ? addr + 32'd4 : addr;  // next word, offset kept
    end
  endtask

  task automatic expect_load(input lsu_access_pkg::access_size_e size, input logic sext,
                             input logic [31:0] addr, input int grants);
    logic [31:0] exp;
    exp = load_value(size, sext, addr);
    run_access(1'b0, size, sext, addr, '0);
    check_value(res_rdata, exp, $sformatf("load data at %h", addr));
    check_value(res_rdata_valid, 1'b1, $sformatf("rdata valid at %h", addr));
    check_value(res_load_err | res_store_err, 1'b0, $sformatf("error flag at %h", addr));
    check_value(res_grants, grants, $sformatf("bus requests for load at %h", addr));
    check_value(res_rvalids, grants, $sformatf("bus responses before load response at %h",
                                               addr));
    check_value(res_incr, grants == 2, $sformatf("address increment for %h", addr));
  endtask

  task automatic expect_store(input lsu_access_pkg::access_size_e size,
                              input logic [31:0] addr, input int grants);
    logic [31:0] wdata;
    logic [31:0] a;
    int          i;
    wdata = random_bits(32);
    for (i = 0; i < size_bytes(size); i++) begin
      a = addr + i;
      exp_mem[a[5:2]][8*a[1:0] +: 8] = wdata[8*i +: 8];
    end
    run_access(1'b1, size, 1'b0, addr, wdata);
    check_value(res_rdata_valid | res_load_err | res_store_err, 1'b0,
                $sformatf("store flags at %h", addr));
    check_value(res_grants, grants, $sformatf("bus requests for store at %h", addr));
    check_value(res_rvalids, grants, $sformatf("bus responses before store response at %h",
                                               addr));
    for (i = 0; i < 16; i++) begin
      check_value(mem[i], exp_mem[i], $sformatf("word %0d after store at %h", i, addr));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_aligned_word();
    int e;
    e = err_cnt;
    @(negedge clk);
    check_value({data_req, addr_incr, busy, load_err, store_err}, '0, "outputs after reset");
    expect_store(lsu_access_pkg::SIZE_WORD, 32'h10, 1);
    expect_load(lsu_access_pkg::SIZE_WORD, 1'b0, 32'h10, 1);
    check_value(res_addr_last, 32'h10, "addr_last_o after aligned load");
    report_test("aligned_word", e);
  endtask

  task automatic test_narrow_loads();
    int e;
    int off;
    int s;
    e = err_cnt;
    for (s = 0; s < 2; s++) begin
      for (off = 0; off < 4; off++) begin
        expect_load(lsu_access_pkg::SIZE_BYTE, s[0], 32'h24 + off, 1);
        expect_load(lsu_access_pkg::SIZE_HALF, s[0], 32'h28 + off, (off == 3) ? 2 : 1);
      end
    end
    report_test("narrow_loads", e);
  endtask

  task automatic test_split_loads();
    int e;
    int off;
    e = err_cnt;
    for (off = 1; off < 4; off++) begin
      expect_load(lsu_access_pkg::SIZE_WORD, 1'b0, 32'h30 + off, 2);
    end
    report_test("split_loads", e);
  endtask

  task automatic test_split_stores();
    int e;
    e = err_cnt;
    expect_store(lsu_access_pkg::SIZE_WORD, 32'h05, 2);
    expect_store(lsu_access_pkg::SIZE_WORD, 32'h0A, 2);
    expect_store(lsu_access_pkg::SIZE_WORD, 32'h0F, 2);
    expect_store(lsu_access_pkg::SIZE_HALF, 32'h17, 2);  // spill byte into next word
    report_test("split_stores", e);
  endtask

  task automatic test_slow_grants();
    int e;
    e = err_cnt;
    gnt_delay = 3;
    expect_store(lsu_access_pkg::SIZE_WORD, 32'h38, 1);
    expect_load(lsu_access_pkg::SIZE_WORD, 1'b0, 32'h38, 1);
    expect_load(lsu_access_pkg::SIZE_HALF, 1'b1, 32'h2B, 2);
    expect_load(lsu_access_pkg::SIZE_WORD, 1'b0, 32'h39, 2);
    expect_store(lsu_access_pkg::SIZE_WORD, 32'h1D, 2);
    gnt_delay = 0;
    report_test("slow_grants", e);
  endtask

  task automatic test_first_part_error();
    int e;
    e = err_cnt;
    err_word = 4'd8;                               // first word of the load below
    err_en   = 1'b1;
    run_access(1'b0, lsu_access_pkg::SIZE_WORD, 1'b0, 32'h22, '0);
    err_en   = 1'b0;
    check_value(res_load_err, 1'b1, "load_err_o on first part error");
    check_value(res_store_err, 1'b0, "store_err_o on a load");
    check_value(res_rdata_valid, 1'b0, "rdata valid despite bus error");
    check_value(res_grants, 2, "bus requests for failing split load");
    check_value(res_rvalids, 2, "core response before the second bus response");
    check_value(res_addr_last, 32'h22, "addr_last_o keeps the failing address");
    report_test("first_part_err", e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    clk         = 1'b0;
    rst_n       = 1'b0;
    lsu_req     = 1'b0;
    lsu_cmd     = '0;
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_err    = 1'b0;
    data_rdata  = '0;
    nxt_gnt     = 1'b0;
    nxt_rvalid  = 1'b0;
    nxt_err     = 1'b0;
    nxt_rdata   = '0;
    gnt_delay   = 0;
    wait_cnt    = 0;
    err_en      = 1'b0;
    err_word    = '0;
    check_cnt   = 0;
    err_cnt     = 0;
    test_cnt    = 0;
    lfsr        = 8'd63;
    for (i = 0; i < 16; i++) begin
      mem[i]     = random_bits(32);
      exp_mem[i] = mem[i];
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_aligned_word();
    test_narrow_loads();
    test_split_loads();
    test_split_stores();
    test_slow_grants();
    test_first_part_error();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(WatchdogNs);
    $display("watchdog expired after %0d ns, a bus or core handshake never completed",
             WatchdogNs);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/lsu_top.sv
// load/store unit top level
// connects the FSM and the store and load data paths to core and bus ports

`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int unsigned AddrWidth = 32
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // execute stage side
  input  wire logic                     lsu_req_i,
  input  wire lsu_access_pkg::lsu_cmd_t lsu_cmd_i,
  output lsu_bus_pkg::data_t            lsu_rdata_o,
  output logic                          lsu_rdata_valid_o,
  output logic                          lsu_resp_valid_o,
  output logic                          lsu_req_done_o,
  output logic                          addr_incr_req_o,
  output logic [AddrWidth-1:0]          addr_last_o,
  output logic                          load_err_o,
  output logic                          store_err_o,
  output logic                          busy_o,
  // data bus side
  output logic                          data_req_o,
  output lsu_bus_pkg::bus_req_t         bus_req_o,
  input  wire logic                     data_gnt_i,
  input  wire logic                     data_rvalid_i,
  input  wire logic                     data_err_i,
  input  wire lsu_bus_pkg::data_t       data_rdata_i
);

  logic                      ctrl_update;
  logic                      rdata_update;
  logic                      split_second;
  lsu_access_pkg::lsu_ctrl_t ctrl;        // captured context, we bit used by FSM

  lsu_fsm #(
    .AddrWidth (AddrWidth)
  ) u_fsm (
    .clk_i, .rst_ni, .lsu_req_i,
    .cmd_i            (lsu_cmd_i),
    .ctrl_we_i        (ctrl.we),
    .data_gnt_i, .data_rvalid_i, .data_err_i,
    .data_req_o, .addr_incr_req_o,
    .ctrl_update_o    (ctrl_update),
    .rdata_update_o   (rdata_update),
    .split_second_o   (split_second),
    .lsu_req_done_o, .lsu_resp_valid_o, .lsu_rdata_valid_o,
    .load_err_o, .store_err_o, .addr_last_o, .busy_o
  );

  lsu_store_align u_store_align (
    .cmd_i          (lsu_cmd_i),
    .split_second_i (split_second),
    .bus_req_o
  );

  lsu_load_align u_load_align (
    .clk_i, .rst_ni,
    .cmd_i          (lsu_cmd_i),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .data_rdata_i,
    .ctrl_o         (ctrl),
    .lsu_rdata_o
  );

endmodule

`default_nettype wire

// File: hw/lsu_load_align.sv
// load side data path
// captured transaction context, first-part rdata holding register,
// word/half/byte realignment and sign or zero extension

`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire lsu_access_pkg::lsu_cmd_t cmd_i,
  input  wire logic                     ctrl_update_i,  // capture context at grant
  input  wire logic                     rdata_update_i, // capture first response word
  input  wire lsu_bus_pkg::data_t       data_rdata_i,
  output lsu_access_pkg::lsu_ctrl_t     ctrl_o,
  output lsu_bus_pkg::data_t            lsu_rdata_o
);

  lsu_access_pkg::lsu_ctrl_t ctrl_q;

  logic [31:8]        rdata_q;    // upper bytes of the first part
  lsu_bus_pkg::data_t word_raw;
  logic [15:0]        half_raw;
  logic [7:0]         byte_raw;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q.offset   <= '0;
      ctrl_q.size     <= lsu_access_pkg::SIZE_WORD;
      ctrl_q.sign_ext <= 1'b0;
      ctrl_q.we       <= 1'b0;
    end else if (ctrl_update_i) begin
      ctrl_q.offset   <= cmd_i.addr[1:0];
      ctrl_q.size     <= cmd_i.size;
      ctrl_q.sign_ext <= cmd_i.sign_ext;
      ctrl_q.we       <= cmd_i.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[31:8];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // realignment
  ////////////////////////////////////////////////////////////////////////////

  // low bytes come from the held first word, high bytes from the current one
  always_comb begin
    unique case (ctrl_q.offset)
      2'b00:   word_raw = data_rdata_i;
      2'b01:   word_raw = {data_rdata_i[7:0],  rdata_q[31:8]};
      2'b10:   word_raw = {data_rdata_i[15:0], rdata_q[31:16]};
      default: word_raw = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    unique case (ctrl_q.offset)
      2'b00:   half_raw = data_rdata_i[15:0];
      2'b01:   half_raw = data_rdata_i[23:8];
      2'b10:   half_raw = data_rdata_i[31:16];
      default: half_raw = {data_rdata_i[7:0], rdata_q[31:24]}; // crosses the word boundary
    endcase
  end

  assign byte_raw = data_rdata_i[{ctrl_q.offset, 3'b000} +: 8]; // byte never splits

  // extension by captured size and sign flag
  always_comb begin
    unique case (ctrl_q.size)
      lsu_access_pkg::SIZE_WORD: lsu_rdata_o = word_raw;
      lsu_access_pkg::SIZE_HALF: lsu_rdata_o = {{16{ctrl_q.sign_ext & half_raw[15]}}, half_raw};
      default:                   lsu_rdata_o = {{24{ctrl_q.sign_ext & byte_raw[7]}}, byte_raw};
    endcase
  end

  assign ctrl_o = ctrl_q;

endmodule

`default_nettype wire

// File: hw/lsu_store_align.sv
// store side data path
// byte-enable generation, store data rotation and word-aligned bus address

`timescale 1ns/1ps
`default_nettype none

module lsu_store_align (
  input  wire lsu_access_pkg::lsu_cmd_t cmd_i,
  input  wire logic                     split_second_i, // second part of a split access
  output lsu_bus_pkg::bus_req_t         bus_req_o
);

  lsu_bus_pkg::offset_t offset;
  lsu_bus_pkg::be_t     be;
  lsu_bus_pkg::data_t   wdata;

  assign offset = cmd_i.addr[1:0];

  // lanes touched by this part of the access
  always_comb begin
    unique case (cmd_i.size)
      lsu_access_pkg::SIZE_WORD: begin
        if (!split_second_i) begin
          be = 4'b1111 << offset;               // lanes from offset up to lane 3
        end else begin
          be = 4'b1111 >> (3'd4 - offset);      // remaining low lanes, offset 1 gives lane 0
        end
      end
      lsu_access_pkg::SIZE_HALF: begin
        if (!split_second_i) begin
          be = 4'b0011 << offset;               // offset 3 leaves only lane 3
        end else begin
          be = 4'b0001;                         // spill byte of offset 3
        end
      end
      default: be = 4'b0001 << offset;          // byte, also the spare code
    endcase
  end

  // rotate left by the offset so each byte lands in its lane
  always_comb begin
    unique case (offset)
      2'b00:   wdata = cmd_i.wdata;
      2'b01:   wdata = {cmd_i.wdata[23:0], cmd_i.wdata[31:24]};
      2'b10:   wdata = {cmd_i.wdata[15:0], cmd_i.wdata[31:16]};
      default: wdata = {cmd_i.wdata[7:0],  cmd_i.wdata[31:8]};
    endcase
  end

  assign bus_req_o.addr  = {cmd_i.addr[31:2], 2'b00}; // bus is word addressed
  assign bus_req_o.we    = cmd_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata;

endmodule

`default_nettype wire

// File: hw/lsu_fsm.sv
// load/store transaction FSM
// misaligned split decision, first-part error tracking, last-address register
// and the core response qualifiers

`timescale 1ns/1ps
`default_nettype none

module lsu_fsm #(
  parameter int unsigned AddrWidth = 32
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     lsu_req_i,         // level, held until done
  input  wire lsu_access_pkg::lsu_cmd_t cmd_i,
  input  wire logic                     ctrl_we_i,         // captured write enable
  input  wire logic                     data_gnt_i,
  input  wire logic                     data_rvalid_i,
  input  wire logic                     data_err_i,        // only valid with rvalid
  output logic                          data_req_o,
  output logic                          addr_incr_req_o,   // ask EX for next word address
  output logic                          ctrl_update_o,
  output logic                          rdata_update_o,
  output logic                          split_second_o,    // second part in flight
  output logic                          lsu_req_done_o,
  output logic                          lsu_resp_valid_o,
  output logic                          lsu_rdata_valid_o,
  output logic                          load_err_o,
  output logic                          store_err_o,
  output logic [AddrWidth-1:0]          addr_last_o,       // trap value source
  output logic                          busy_o
);

  lsu_access_pkg::ls_state_e state_q, state_d;

  logic                 split_access;            // needs two bus transactions
  logic                 mis_q, mis_d;            // high between first grant and second grant
  logic                 err_q, err_d;            // bus error of the first part
  logic                 err_any;
  logic                 addr_update;
  logic [AddrWidth-1:0] addr_cur;
  logic [AddrWidth-1:0] addr_last_q;

  assign addr_cur = AddrWidth'(cmd_i.addr);

  // word off alignment, or halfword crossing into the next word
  assign split_access =
      ((cmd_i.size == lsu_access_pkg::SIZE_WORD) && (cmd_i.addr[1:0] != 2'b00)) ||
      ((cmd_i.size == lsu_access_pkg::SIZE_HALF) && (cmd_i.addr[1:0] == 2'b11));

  ////////////////////////////////////////////////////////////////////////////
  // next state and update strobes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    mis_d           = mis_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    addr_update     = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;

    unique case (state_q)
      lsu_access_pkg::IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          err_d      = 1'b0;            // fresh transaction
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            mis_d         = split_access;
            state_d       = split_access ? lsu_access_pkg::WAIT_RVALID_MIS : lsu_access_pkg::IDLE;
          end else begin
            state_d       = split_access ? lsu_access_pkg::WAIT_GNT_MIS : lsu_access_pkg::WAIT_GNT;
          end
        end
      end

      lsu_access_pkg::WAIT_GNT_MIS: begin
        data_req_o = 1'b1;              // first part, hold until granted
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          mis_d         = 1'b1;
          state_d       = lsu_access_pkg::WAIT_RVALID_MIS;
        end
      end

      lsu_access_pkg::WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1;         // second part goes out right away
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_err_i;  // remember first-part result
          rdata_update_o = ~ctrl_we_i;  // keep upper bytes for realignment
          addr_update    = data_gnt_i & ~data_err_i;
          mis_d          = ~data_gnt_i;
          state_d        = data_gnt_i ? lsu_access_pkg::IDLE : lsu_access_pkg::WAIT_GNT;
        end else if (data_gnt_i) begin
          mis_d   = 1'b0;               // second granted before first response
          state_d = lsu_access_pkg::WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      lsu_access_pkg::WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = mis_q;        // only for the second part of a split
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~err_q;       // keep the first failing address
          mis_d         = 1'b0;
          state_d       = lsu_access_pkg::IDLE;
        end
      end

      lsu_access_pkg::WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_req_o = 1'b1;         // EX still presents the second address
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          addr_update    = ~data_err_i;
          rdata_update_o = ~ctrl_we_i;
          state_d        = lsu_access_pkg::IDLE;
        end
      end

      default: state_d = lsu_access_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= lsu_access_pkg::IDLE;
      mis_q       <= 1'b0;
      err_q       <= 1'b0;
      addr_last_q <= '0;
    end else begin
      state_q <= state_d;
      mis_q   <= mis_d;
      err_q   <= err_d;
      if (addr_update) begin
        addr_last_q <= addr_cur;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // core side outputs
  ////////////////////////////////////////////////////////////////////////////

  assign err_any           = err_q | data_err_i;  // either part failed
  assign lsu_req_done_o    = (lsu_req_i | (state_q != lsu_access_pkg::IDLE)) &
                             (state_d == lsu_access_pkg::IDLE);
  assign lsu_resp_valid_o  = data_rvalid_i & (state_q == lsu_access_pkg::IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~err_any & ~ctrl_we_i;
  assign load_err_o        = lsu_resp_valid_o & err_any & ~ctrl_we_i;
  assign store_err_o       = lsu_resp_valid_o & err_any &  ctrl_we_i;
  assign split_second_o    = mis_q;
  assign addr_last_o       = addr_last_q;
  assign busy_o            = (state_q != lsu_access_pkg::IDLE);

endmodule

`default_nettype wire

// File: hw/lsu_access_pkg.sv
// core side types for the load/store unit
// access size and FSM state enums, command and captured-control structs

`default_nettype none

package lsu_access_pkg;

  // access size as encoded by the decoder, code 2'b11 is treated as byte too
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } access_size_e;

  // transaction sequencer states
  typedef enum logic [2:0] {
    IDLE,                      // no request outstanding in the address phase
    WAIT_GNT_MIS,              // first part of a split access waits for grant
    WAIT_RVALID_MIS,           // first part granted, second part requested
    WAIT_GNT,                  // single or second part waits for grant
    WAIT_RVALID_MIS_GNTS_DONE  // both granted, first rvalid still pending
  } ls_state_e;

  // request from the execute stage
  typedef struct packed {
    logic                we;       // 1 = store
    access_size_e        size;
    logic                sign_ext; // sign extend loaded half/byte
    lsu_bus_pkg::data_t  wdata;    // store data, unrotated
    lsu_bus_pkg::addr_t  addr;     // byte address, may be misaligned
  } lsu_cmd_t;

  // context held for the response phase
  typedef struct packed {
    lsu_bus_pkg::offset_t offset;
    access_size_e         size;
    logic                 sign_ext;
    logic                 we;
  } lsu_ctrl_t;

endpackage

`default_nettype wire

// File: hw/lsu_bus_pkg.sv
// data bus side types for the load/store unit
// address, data, byte-enable and offset vectors plus the bus request struct

`default_nettype none

package lsu_bus_pkg;

  // bus data path width, byte-lane logic assumes four lanes
  localparam int unsigned DataWidth = 32;

  typedef logic [31:0]            addr_t;   // byte address, always 32 bit on the bus
  typedef logic [DataWidth-1:0]   data_t;   // store data, load data, bus read data
  typedef logic [DataWidth/8-1:0] be_t;     // one enable per byte lane
  typedef logic [1:0]             offset_t; // byte offset within a word

  ////////////////////////////////////////////////////////////////////////////
  // request payload, the req strobe travels separately
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    addr_t addr;  // word aligned
    logic  we;    // 1 = store
    be_t   be;    // active byte lanes
    data_t wdata; // already rotated into lane position
  } bus_req_t;

endpackage

`default_nettype wire
